//--- verilog/fifo_cfg_pkg.sv
// default FIFO geometry and flag offsets, used only as top-level parameter defaults
// offsets must stay below the depth given by the chosen pointer width
`default_nettype none

package fifo_cfg_pkg;

    // ========================================================================
    // default geometry
    // ========================================================================

    // data word width in bits
    localparam int DEF_DATA_WIDTH = 16;
    // address width, 4 bits gives 16 entries
    localparam int DEF_PTR_WIDTH = 4;

    // ========================================================================
    // default flag thresholds
    // ========================================================================

    // almost-full asserts at depth minus this many entries
    localparam int DEF_ALMOSTFULL_OFFSET = 2;
    // almost-empty asserts at or below this many entries
    localparam int DEF_ALMOSTEMPTY_OFFSET = 2;

    // number of entries for a given address width
    function automatic int unsigned fifo_depth(input int unsigned ptr_w);
        return 32'd1 << ptr_w;
    endfunction

endpackage

`default_nettype wire

//--- verilog/gray_ptr_pkg.sv
// Gray-code helpers for pointers that cross clock domains
// pointers narrower than PTR_MAX_W+1 bits are zero-extended on the way in
`default_nettype none

package gray_ptr_pkg;

    // ========================================================================
    // pointer word
    // ========================================================================

    // widest address width the helpers cover
    localparam int PTR_MAX_W = 15;

    // address plus one wrap bit, so full and empty can be told apart
    typedef logic [PTR_MAX_W:0] gptr_t;

    // ========================================================================
    // conversions
    // ========================================================================

    // binary to Gray
    // only one bit flips per increment, safe to sample in another domain
    // zero-extension in front leaves the Gray value unchanged
    function automatic gptr_t bin2gray(input gptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    // Gray back to binary
    // each binary bit is the xor of all Gray bits at and above it
    // runs from the top bit down, leading zeros stay zero
    function automatic gptr_t gray2bin(input gptr_t gray);
        gptr_t bin;
        bin[PTR_MAX_W] = gray[PTR_MAX_W];
        for (int i = PTR_MAX_W - 1; i >= 0; i--) begin
            bin[i] = bin[i + 1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

`default_nettype wire

//--- verilog/fifo_dpram.sv
// FIFO storage, one write port on i_wclk and a combinational read port
// no reset on the array, so it maps onto distributed RAM
`timescale 1ns/10ps
`default_nettype none

module fifo_dpram #(
    parameter int DATA_WIDTH = 16,
    parameter int PTR_WIDTH  = 4
) (
    input  wire logic                  i_wclk,
    input  wire logic                  i_we,
    input  wire logic [PTR_WIDTH-1:0]  i_waddr,
    input  wire logic [DATA_WIDTH-1:0] i_wdata,
    input  wire logic [PTR_WIDTH-1:0]  i_raddr,
    output logic      [DATA_WIDTH-1:0] o_rdata
);

    localparam int DEPTH = 1 << PTR_WIDTH;

    // storage words, contents undefined until written
    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // write port
    // i_we already carries the not-full qualification
    always_ff @(posedge i_wclk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // read port
    // asynchronous, so the head word falls through as soon as
    // the read address moves
    assign o_rdata = mem[i_raddr];

endmodule

`default_nettype wire

//--- verilog/wr_ptr_full.sv
// write side of the dual-clock FIFO: write pointer, read-pointer sync, full flags
// i_wr while full is dropped; fill and flags are pessimistic by the sync delay
// PTR_WIDTH must lie in 2..PTR_MAX_W and ALMOSTFULL_OFFSET below the depth
`timescale 1ns/10ps
`default_nettype none

module wr_ptr_full
    import fifo_cfg_pkg::*;
    import gray_ptr_pkg::*;
#(
    parameter int PTR_WIDTH         = DEF_PTR_WIDTH,
    parameter int ALMOSTFULL_OFFSET = DEF_ALMOSTFULL_OFFSET
) (
    input  wire logic                 i_wclk,
    input  wire logic                 i_wrstn,
    input  wire logic                 i_wr,
    input  wire logic [PTR_WIDTH:0]   i_rptr_gray,
    output logic                      o_we,
    output logic      [PTR_WIDTH-1:0] o_waddr,
    output logic      [PTR_WIDTH:0]   o_wptr_gray,
    output logic                      o_wfull,
    output logic                      o_walmostfull,
    output logic      [PTR_WIDTH:0]   o_wfill
);

    localparam int unsigned DEPTH = fifo_depth(PTR_WIDTH);
    // fill at which almost-full asserts
    localparam logic [PTR_WIDTH:0] AF_LEVEL = (PTR_WIDTH + 1)'(DEPTH - ALMOSTFULL_OFFSET);
    localparam logic [PTR_WIDTH:0] FILL_MAX = (PTR_WIDTH + 1)'(DEPTH);

    // reject geometries the pointer helpers cannot hold
    if (PTR_WIDTH < 2 || PTR_WIDTH > PTR_MAX_W) begin : g_bad_width
        $error("wr_ptr_full: PTR_WIDTH out of range");
    end
    if (ALMOSTFULL_OFFSET < 0 || ALMOSTFULL_OFFSET >= DEPTH) begin : g_bad_offset
        $error("wr_ptr_full: ALMOSTFULL_OFFSET must be below the depth");
    end

    logic [PTR_WIDTH:0] wbin;
    logic [PTR_WIDTH:0] wbin_next;
    logic [PTR_WIDTH:0] wgray_next;
    // two-flop synchronizer for the read pointer
    logic [PTR_WIDTH:0] wq1_rptr;
    logic [PTR_WIDTH:0] wq2_rptr;
    logic [PTR_WIDTH:0] rbin_sync;
    logic [PTR_WIDTH:0] wfill_next;
    logic               wfull_next;
    logic               walmostfull_next;
    gptr_t              wgray_ext;
    gptr_t              rbin_ext;

    // ========================================================================
    // write pointer
    // ========================================================================

    // accepted write, also the RAM write enable
    assign o_we      = i_wr && !o_wfull;
    assign o_waddr   = wbin[PTR_WIDTH-1:0];
    assign wbin_next = wbin + {{PTR_WIDTH{1'b0}}, o_we};

    assign wgray_ext  = bin2gray(gptr_t'(wbin_next));
    assign wgray_next = wgray_ext[PTR_WIDTH:0];

    // ========================================================================
    // read pointer crossing
    // ========================================================================

    always_ff @(posedge i_wclk or negedge i_wrstn) begin
        if (!i_wrstn) begin
            wq1_rptr <= '0;
            wq2_rptr <= '0;
        end else begin
            wq1_rptr <= i_rptr_gray;
            wq2_rptr <= wq1_rptr;
        end
    end

    // decoded read pointer, lags the real one by the sync delay
    assign rbin_ext  = gray2bin(gptr_t'(wq2_rptr));
    assign rbin_sync = rbin_ext[PTR_WIDTH:0];

    // ========================================================================
    // flags and fill
    // ========================================================================

    // full when the pointers differ by exactly the depth
    // in Gray form that means the top two bits inverted
    assign wfull_next = (wgray_next == {~wq2_rptr[PTR_WIDTH:PTR_WIDTH-1],
                                        wq2_rptr[PTR_WIDTH-2:0]});
    // wraps modulo twice the depth, the extra bit keeps a full FIFO at DEPTH
    assign wfill_next       = wbin_next - rbin_sync;
    assign walmostfull_next = (wfill_next >= AF_LEVEL) || wfull_next;

    // flags registered from next-state values, so an accepted write
    // shows up at the same edge
    always_ff @(posedge i_wclk or negedge i_wrstn) begin
        if (!i_wrstn) begin
            wbin          <= '0;
            o_wptr_gray   <= '0;
            o_wfull       <= 1'b0;
            o_walmostfull <= 1'b0;
            o_wfill       <= '0;
        end else begin
            wbin          <= wbin_next;
            o_wptr_gray   <= wgray_next;
            o_wfull       <= wfull_next;
            o_walmostfull <= walmostfull_next;
            o_wfill       <= wfill_next;
        end
    end

    // never more entries than the array holds
    a_wfill_max: assert property (@(posedge i_wclk) disable iff (!i_wrstn)
        o_wfill <= FILL_MAX);

    // full flag and fill count agree
    a_full_fill: assert property (@(posedge i_wclk) disable iff (!i_wrstn)
        o_wfull |-> (o_wfill == FILL_MAX));

    // no write slips in while full, so full only clears once a
    // newer read pointer has crossed over
    a_full_release: assert property (@(posedge i_wclk) disable iff (!i_wrstn)
        $fell(o_wfull) |-> ($past(wq2_rptr) != $past(wq2_rptr, 2)));

endmodule

`default_nettype wire

//--- verilog/rd_ptr_empty.sv
// read side of the dual-clock FIFO: read pointer, write-pointer sync, empty flags
// i_rd while empty is dropped; fill and flags are pessimistic by the sync delay
// PTR_WIDTH must lie in 2..PTR_MAX_W and ALMOSTEMPTY_OFFSET below the depth
`timescale 1ns/10ps
`default_nettype none

module rd_ptr_empty
    import fifo_cfg_pkg::*;
    import gray_ptr_pkg::*;
#(
    parameter int PTR_WIDTH          = DEF_PTR_WIDTH,
    parameter int ALMOSTEMPTY_OFFSET = DEF_ALMOSTEMPTY_OFFSET
) (
    input  wire logic                 i_rclk,
    input  wire logic                 i_rrstn,
    input  wire logic                 i_rd,
    input  wire logic [PTR_WIDTH:0]   i_wptr_gray,
    output logic      [PTR_WIDTH-1:0] o_raddr,
    output logic      [PTR_WIDTH:0]   o_rptr_gray,
    output logic                      o_rempty,
    output logic                      o_ralmostempty,
    output logic      [PTR_WIDTH:0]   o_rfill
);

    localparam int unsigned DEPTH = fifo_depth(PTR_WIDTH);
    // fill at or below which almost-empty asserts
    localparam logic [PTR_WIDTH:0] AE_LEVEL = (PTR_WIDTH + 1)'(ALMOSTEMPTY_OFFSET);
    localparam logic [PTR_WIDTH:0] FILL_MAX = (PTR_WIDTH + 1)'(DEPTH);

    if (PTR_WIDTH < 2 || PTR_WIDTH > PTR_MAX_W) begin : g_bad_width
        $error("rd_ptr_empty: PTR_WIDTH out of range");
    end
    if (ALMOSTEMPTY_OFFSET < 0 || ALMOSTEMPTY_OFFSET >= DEPTH) begin : g_bad_offset
        $error("rd_ptr_empty: ALMOSTEMPTY_OFFSET must be below the depth");
    end

    logic [PTR_WIDTH:0] rbin;
    logic [PTR_WIDTH:0] rbin_next;
    logic [PTR_WIDTH:0] rgray_next;
    // two-flop synchronizer for the write pointer
    logic [PTR_WIDTH:0] rq1_wptr;
    logic [PTR_WIDTH:0] rq2_wptr;
    logic [PTR_WIDTH:0] wbin_sync;
    logic [PTR_WIDTH:0] rfill_next;
    logic               rd_accept;
    logic               rempty_next;
    logic               ralmostempty_next;
    gptr_t              rgray_ext;
    gptr_t              wbin_ext;

    // ========================================================================
    // read pointer
    // ========================================================================

    assign rd_accept = i_rd && !o_rempty;
    assign rbin_next = rbin + {{PTR_WIDTH{1'b0}}, rd_accept};
    // registered address, the RAM read is combinational so the next
    // word appears in the same cycle after a read
    assign o_raddr   = rbin[PTR_WIDTH-1:0];

    assign rgray_ext  = bin2gray(gptr_t'(rbin_next));
    assign rgray_next = rgray_ext[PTR_WIDTH:0];

    // ========================================================================
    // write pointer crossing
    // ========================================================================

    always_ff @(posedge i_rclk or negedge i_rrstn) begin
        if (!i_rrstn) begin
            rq1_wptr <= '0;
            rq2_wptr <= '0;
        end else begin
            rq1_wptr <= i_wptr_gray;
            rq2_wptr <= rq1_wptr;
        end
    end

    assign wbin_ext  = gray2bin(gptr_t'(rq2_wptr));
    assign wbin_sync = wbin_ext[PTR_WIDTH:0];

    // ========================================================================
    // flags and fill
    // ========================================================================

    // empty once the read pointer catches the synced write pointer
    assign rempty_next       = (rgray_next == rq2_wptr);
    assign rfill_next        = wbin_sync - rbin_next;
    assign ralmostempty_next = (rfill_next <= AE_LEVEL);

    // reset state reads as empty and almost empty
    always_ff @(posedge i_rclk or negedge i_rrstn) begin
        if (!i_rrstn) begin
            rbin           <= '0;
            o_rptr_gray    <= '0;
            o_rempty       <= 1'b1;
            o_ralmostempty <= 1'b1;
            o_rfill        <= '0;
        end else begin
            rbin           <= rbin_next;
            o_rptr_gray    <= rgray_next;
            o_rempty       <= rempty_next;
            o_ralmostempty <= ralmostempty_next;
            o_rfill        <= rfill_next;
        end
    end

    // the synced write pointer never runs more than a depth ahead
    a_rfill_max: assert property (@(posedge i_rclk) disable iff (!i_rrstn)
        o_rfill <= FILL_MAX);

    // Gray compare and binary difference see the same empty state
    a_empty_fill: assert property (@(posedge i_rclk) disable iff (!i_rrstn)
        o_rempty == (o_rfill == '0));

endmodule

`default_nettype wire

//--- verilog/fifo_async.sv
// dual-clock FIFO, first-word fall-through, Gray pointers over two-flop syncs
// flags and fills lag the far side by the sync delay, never optimistic
// o_rdata is valid only while o_rempty is low
`timescale 1ns/10ps
`default_nettype none

module fifo_async
    import fifo_cfg_pkg::*;
#(
    parameter int DATA_WIDTH         = DEF_DATA_WIDTH,
    parameter int PTR_WIDTH          = DEF_PTR_WIDTH,
    parameter int ALMOSTFULL_OFFSET  = DEF_ALMOSTFULL_OFFSET,
    parameter int ALMOSTEMPTY_OFFSET = DEF_ALMOSTEMPTY_OFFSET
) (
    // write domain
    input  wire logic                  i_wclk,
    input  wire logic                  i_wrstn,
    input  wire logic                  i_wr,
    input  wire logic [DATA_WIDTH-1:0] i_wdata,
    output logic                       o_wfull,
    output logic                       o_walmostfull,
    output logic      [PTR_WIDTH:0]    o_wfill,
    // read domain
    input  wire logic                  i_rclk,
    input  wire logic                  i_rrstn,
    input  wire logic                  i_rd,
    output logic      [DATA_WIDTH-1:0] o_rdata,
    output logic                       o_rempty,
    output logic                       o_ralmostempty,
    output logic      [PTR_WIDTH:0]    o_rfill
);

    logic                 we;
    logic [PTR_WIDTH-1:0] waddr;
    logic [PTR_WIDTH-1:0] raddr;
    // Gray pointers, each registered in its own domain
    logic [PTR_WIDTH:0]   wptr_gray;
    logic [PTR_WIDTH:0]   rptr_gray;

    // ========================================================================
    // storage
    // ========================================================================

    fifo_dpram #(
        .DATA_WIDTH (DATA_WIDTH),
        .PTR_WIDTH  (PTR_WIDTH)
    ) u_mem (
        .i_wclk  (i_wclk),
        .i_we    (we),
        .i_waddr (waddr),
        .i_wdata (i_wdata),
        .i_raddr (raddr),
        .o_rdata (o_rdata)
    );

    // ========================================================================
    // write domain
    // ========================================================================

    wr_ptr_full #(
        .PTR_WIDTH         (PTR_WIDTH),
        .ALMOSTFULL_OFFSET (ALMOSTFULL_OFFSET)
    ) u_wr (
        .i_wclk        (i_wclk),
        .i_wrstn       (i_wrstn),
        .i_wr          (i_wr),
        .i_rptr_gray   (rptr_gray),
        .o_we          (we),
        .o_waddr       (waddr),
        .o_wptr_gray   (wptr_gray),
        .o_wfull       (o_wfull),
        .o_walmostfull (o_walmostfull),
        .o_wfill       (o_wfill)
    );

    // ========================================================================
    // read domain
    // ========================================================================

    rd_ptr_empty #(
        .PTR_WIDTH          (PTR_WIDTH),
        .ALMOSTEMPTY_OFFSET (ALMOSTEMPTY_OFFSET)
    ) u_rd (
        .i_rclk         (i_rclk),
        .i_rrstn        (i_rrstn),
        .i_rd           (i_rd),
        .i_wptr_gray    (wptr_gray),
        .o_raddr        (raddr),
        .o_rptr_gray    (rptr_gray),
        .o_rempty       (o_rempty),
        .o_ralmostempty (o_ralmostempty),
        .o_rfill        (o_rfill)
    );

endmodule

`default_nettype wire

//--- bench/fifo_async_tb.sv
// two-clock random testbench for the dual-clock FIFO at its default geometry
// a queue model follows every accepted write and read
// inputs change on the falling edge of their own clock
`timescale 1ns/10ps
`default_nettype none

module fifo_async_tb
    import fifo_cfg_pkg::*;
();

    localparam int DEPTH = 1 << DEF_PTR_WIDTH;
    localparam int DW    = DEF_DATA_WIDTH;

    logic                   i_wclk;
    logic                   i_wrstn;
    logic                   i_wr;
    logic [DW-1:0]          i_wdata;
    logic                   o_wfull;
    logic                   o_walmostfull;
    logic [DEF_PTR_WIDTH:0] o_wfill;
    logic                   i_rclk;
    logic                   i_rrstn;
    logic                   i_rd;
    logic [DW-1:0]          o_rdata;
    logic                   o_rempty;
    logic                   o_ralmostempty;
    logic [DEF_PTR_WIDTH:0] o_rfill;

    // reference model with the oldest word at the front
    logic [DW-1:0] model [$];
    logic [31:0]   lcg_state;
    int            errors;
    int            tests_passed;
    int            tests_failed;
    logic          writer_done;

    fifo_async UUT (
        .i_wclk         (i_wclk),
        .i_wrstn        (i_wrstn),
        .i_wr           (i_wr),
        .i_wdata        (i_wdata),
        .o_wfull        (o_wfull),
        .o_walmostfull  (o_walmostfull),
        .o_wfill        (o_wfill),
        .i_rclk         (i_rclk),
        .i_rrstn        (i_rrstn),
        .i_rd           (i_rd),
        .o_rdata        (o_rdata),
        .o_rempty       (o_rempty),
        .o_ralmostempty (o_ralmostempty),
        .o_rfill        (o_rfill)
    );

    // ========================================================================
    // clocks
    // ========================================================================

    // write clock with a 4 ns period
    initial begin
        i_wclk = 1'b0;
        forever #2 i_wclk = ~i_wclk;
    end

    // read clock with a 6 ns period
    // offset by 1 ns so its falling edges land on odd times
    // and never meet an edge of the write clock
    initial begin
        i_rclk = 1'b0;
        #1;
        forever #3 i_rclk = ~i_rclk;
    end

    // ========================================================================
    // helpers
    // ========================================================================

    // linear congruential generator whose upper bits are the useful ones
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    // one write cycle
    // o_wfull holds from here to the next rising edge
    task automatic drive_write(input logic wr);
        logic [31:0] r;
        r = next_random();
        @(negedge i_wclk);
        i_wr    = wr;
        i_wdata = r[31 -: DW];
        if (wr && !o_wfull) begin
            model.push_back(i_wdata);
        end
    endtask

    // one read cycle
    // an accepted read must show the model head
    task automatic drive_read(input logic rd, input string name);
        @(negedge i_rclk);
        i_rd = rd;
        if (rd && !o_rempty) begin
            if (model.size() == 0) begin
                $display("%s: read accepted while the model holds no data", name);
                errors++;
            end else begin
                compare(name, 32'(model.pop_front()), 32'(o_rdata));
            end
        end
    endtask

    // both sides idle long enough for the pointers to cross
    task automatic settle(input string name);
        fork
            repeat (10) drive_write(1'b0);
            repeat (10) drive_read(1'b0, name);
        join
    endtask

    // read until the DUT stays empty after all writes in flight have crossed
    task automatic drain(input string name);
        int n;
        n = 0;
        while (n < 200) begin
            if (o_rempty) begin
                settle(name);
                if (o_rempty) begin
                    break;
                end
            end
            drive_read(1'b1, name);
            n++;
        end
        drive_read(1'b0, name);
        if (n >= 200) begin
            $display("%s: timed out waiting for the FIFO to drain", name);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %s: pass", name);
            tests_passed++;
        end else begin
            $display("test %s: fail, %0d errors", name, errors - errs_before);
            tests_failed++;
        end
    endtask

    // ========================================================================
    // test sequence
    // ========================================================================

    initial begin
        int          e0;
        int          n;
        int          nw;
        int          nr;
        logic [31:0] r;
        logic [31:0] written;

        i_wrstn      = 1'b0;
        i_rrstn      = 1'b0;
        i_wr         = 1'b0;
        i_rd         = 1'b0;
        i_wdata      = '0;
        lcg_state    = 32'he33b;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        writer_done  = 1'b0;

        // each reset held for 8 cycles of its own clock
        fork
            begin
                repeat (8) @(negedge i_wclk);
                i_wrstn = 1'b1;
            end
            begin
                repeat (8) @(negedge i_rclk);
                i_rrstn = 1'b1;
            end
        join

        // reset state
        e0 = errors;
        compare("reset", 32'(1), 32'(o_rempty));
        compare("reset", 32'(1), 32'(o_ralmostempty));
        compare("reset", 32'(0), 32'(o_wfull));
        compare("reset", 32'(0), 32'(o_walmostfull));
        compare("reset", 32'(0), 32'(o_wfill));
        compare("reset", 32'(0), 32'(o_rfill));
        end_test("reset", e0);

        // fill to full with reads held off
        e0 = errors;
        n  = 0;
        while (n < 100) begin
            if (o_wfull) begin
                break;
            end
            drive_write(1'b1);
            n++;
        end
        if (n >= 100) begin
            $display("fill_full: timed out waiting for o_wfull");
            errors++;
        end
        drive_write(1'b0);
        compare("fill_full", 32'(DEPTH), 32'(model.size()));
        compare("fill_full", 32'(DEPTH), 32'(o_wfill));
        // writes against a full FIFO must be dropped
        repeat (5) drive_write(1'b1);
        drive_write(1'b0);
        compare("fill_full", 32'(DEPTH), 32'(model.size()));
        compare("fill_full", 32'(DEPTH), 32'(o_wfill));
        end_test("fill_full", e0);

        // concurrent random traffic with the order checked at every read
        e0 = errors;
        writer_done = 1'b0;
        fork
            begin
                repeat (2000) begin
                    r = next_random();
                    drive_write(r[20]);
                end
                drive_write(1'b0);
                writer_done = 1'b1;
            end
            begin : reader
                int cnt;
                logic [31:0] rr;
                cnt = 0;
                while (!writer_done && cnt < 4000) begin
                    rr = next_random();
                    drive_read(rr[20], "random_traffic");
                    cnt++;
                end
                drive_read(1'b0, "random_traffic");
                if (cnt >= 4000) begin
                    $display("random_traffic: reader timed out waiting for the writer");
                    errors++;
                end
            end
        join
        drain("random_traffic");
        compare("random_traffic", 32'(0), 32'(model.size()));
        compare("random_traffic", 32'(0), 32'(o_rfill));
        end_test("random_traffic", e0);

        // partial fills followed by flag and fill checks after idle
        e0 = errors;
        repeat (4) begin
            r  = next_random();
            nw = int'(r[19:16]);
            nr = int'(r[23:21]);
            repeat (nw) drive_write(1'b1);
            drive_write(1'b0);
            repeat (nr) drive_read(1'b1, "quiescent");
            drive_read(1'b0, "quiescent");
            settle("quiescent");
            compare("quiescent", 32'(model.size()), 32'(o_wfill));
            compare("quiescent", 32'(model.size()), 32'(o_rfill));
            compare("quiescent", 32'(model.size() >= DEPTH - DEF_ALMOSTFULL_OFFSET),
                    32'(o_walmostfull));
            compare("quiescent", 32'(model.size() <= DEF_ALMOSTEMPTY_OFFSET),
                    32'(o_ralmostempty));
            compare("quiescent", 32'(model.size() == DEPTH), 32'(o_wfull));
            compare("quiescent", 32'(model.size() == 0), 32'(o_rempty));
        end
        end_test("quiescent", e0);

        // read strobes against an empty FIFO and then a single word
        e0 = errors;
        drain("empty_reads");
        settle("empty_reads");
        repeat (8) begin
            drive_read(1'b1, "empty_reads");
            compare("empty_reads", 32'(1), 32'(o_rempty));
            compare("empty_reads", 32'(0), 32'(o_rfill));
        end
        drive_read(1'b0, "empty_reads");
        drive_write(1'b1);
        drive_write(1'b0);
        written = 32'(model[0]);
        settle("empty_reads");
        compare("empty_reads", 32'(0), 32'(o_wfull));
        compare("empty_reads", 32'(0), 32'(o_walmostfull));
        compare("empty_reads", 32'(1), 32'(o_wfill));
        n = 0;
        while (n < 50) begin
            if (!o_rempty) begin
                break;
            end
            drive_read(1'b0, "empty_reads");
            n++;
        end
        if (n >= 50) begin
            $display("empty_reads: timed out waiting for o_rempty to fall");
            errors++;
        end
        compare("empty_reads", 32'(1), 32'(o_rfill));
        compare("empty_reads", written, 32'(o_rdata));
        drive_read(1'b1, "empty_reads");
        drive_read(1'b0, "empty_reads");
        // the only word is gone, so empty returns at the edge of the read
        compare("empty_reads", 32'(1), 32'(o_rempty));
        compare("empty_reads", 32'(0), 32'(o_rfill));
        end_test("empty_reads", e0);

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
verilog/fifo_cfg_pkg.sv
verilog/gray_ptr_pkg.sv
verilog/fifo_dpram.sv
verilog/wr_ptr_full.sv
verilog/rd_ptr_empty.sv
verilog/fifo_async.sv
bench/fifo_async_tb.sv

//--- Makefile
# Verilator build and run for the dual-clock FIFO testbench

TOP = fifo_async_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
